//--- hdl/ps_bus_pkg.sv
// PS system-bus package
// Bus widths, AXI response codes and the default acknowledge timeout
// shared by the AXI4-Lite slave and the system-bus controller.

`default_nettype none

package ps_bus_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int ADDR_W_DEF = 32;        // default address width
  localparam int DATA_W     = 32;        // system bus word, fixed
  localparam int STRB_W     = DATA_W / 8; // one strobe per byte

  // ------------------------------
  // AXI response codes
  // ------------------------------
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // cycles to wait for sys_ack_i before giving up
  localparam int ACK_TIMEOUT_DEF = 32;

endpackage : ps_bus_pkg

`default_nettype wire

//--- hdl/axil_wr_channel.sv
// AXI4-Lite write channel
// Captures AW and W in either order, hands one write request to the
// system-bus controller and returns the write response on B.

`default_nettype none

module axil_wr_channel #(
  parameter int ADDR_W = ps_bus_pkg::ADDR_W_DEF
) (
  input  logic                          axi0_clk_i,
  input  logic                          rst_n_i,
  // AXI4-Lite write address
  input  logic [ADDR_W-1:0]             awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  // AXI4-Lite write data
  input  logic [ps_bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [ps_bus_pkg::STRB_W-1:0] wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  // AXI4-Lite write response
  output ps_bus_pkg::axi_resp_t         bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  // request to bus controller
  output logic                          wr_req_o,
  output logic [ADDR_W-1:0]             wr_addr_o,
  output logic [ps_bus_pkg::DATA_W-1:0] wr_data_o,
  output logic [ps_bus_pkg::STRB_W-1:0] wr_strb_o,
  input  logic                          wr_done_i,
  input  ps_bus_pkg::axi_resp_t         wr_resp_i
);

  import ps_bus_pkg::*;

  logic aw_full;  // address held
  logic w_full;   // data held
  logic aw_fire;
  logic w_fire;

  assign awready_o = ~aw_full;
  assign wready_o  = ~w_full;
  assign aw_fire   = awvalid_i & awready_o;
  assign w_fire    = wvalid_i & wready_o;

  // ------------------------------
  // handshake and request control
  // ------------------------------
  always_ff @(posedge axi0_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_full  <= 1'b0;
      w_full   <= 1'b0;
      wr_req_o <= 1'b0;
      bvalid_o <= 1'b0;
      bresp_o  <= RESP_OKAY;
    end else begin
      if (aw_fire)
        aw_full <= 1'b1;
      if (w_fire)
        w_full <= 1'b1;
      if (aw_full && w_full && !wr_req_o && !bvalid_o)
        wr_req_o <= 1'b1;  // both halves present
      if (wr_done_i) begin
        wr_req_o <= 1'b0;
        bvalid_o <= 1'b1;
        bresp_o  <= wr_resp_i;
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        aw_full  <= 1'b0;  // reopen both channels
        w_full   <= 1'b0;
      end
    end
  end

  // holding registers
  always_ff @(posedge axi0_clk_i) begin
    if (aw_fire)
      wr_addr_o <= awaddr_i;
    if (w_fire) begin
      wr_data_o <= wdata_i;
      wr_strb_o <= wstrb_i;
    end
  end

endmodule : axil_wr_channel

`default_nettype wire

//--- hdl/axil_rd_channel.sv
// AXI4-Lite read channel
// Accepts one read address at a time, requests the bus read and holds
// the returned data and response on R until the master takes them.

`default_nettype none

module axil_rd_channel #(
  parameter int ADDR_W = ps_bus_pkg::ADDR_W_DEF
) (
  input  logic                          axi0_clk_i,
  input  logic                          rst_n_i,
  // AXI4-Lite read address
  input  logic [ADDR_W-1:0]             araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  // AXI4-Lite read data
  output logic [ps_bus_pkg::DATA_W-1:0] rdata_o,
  output ps_bus_pkg::axi_resp_t         rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  // request to bus controller
  output logic                          rd_req_o,
  output logic [ADDR_W-1:0]             rd_addr_o,
  input  logic                          rd_done_i,
  input  ps_bus_pkg::axi_resp_t         rd_resp_i,
  input  logic [ps_bus_pkg::DATA_W-1:0] rd_data_i
);

  import ps_bus_pkg::*;

  logic ar_fire;

  // busy from accepted address until R is taken
  assign arready_o = ~(rd_req_o | rvalid_o);
  assign ar_fire   = arvalid_i & arready_o;

  always_ff @(posedge axi0_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_req_o <= 1'b0;
      rvalid_o <= 1'b0;
      rresp_o  <= RESP_OKAY;
    end else begin
      if (ar_fire)
        rd_req_o <= 1'b1;
      if (rd_done_i) begin
        rd_req_o <= 1'b0;
        rvalid_o <= 1'b1;
        rresp_o  <= rd_resp_i;
      end
      if (rvalid_o && rready_i)
        rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge axi0_clk_i) begin
    if (ar_fire)
      rd_addr_o <= araddr_i;
    if (rd_done_i)
      rdata_o <= rd_data_i;  // held until rready
  end

endmodule : axil_rd_channel

`default_nettype wire

//--- hdl/sys_bus_ctrl.sv
// System-bus controller
// Serves write and read requests one at a time on the simple system bus,
// alternating between the two when both wait. A missing acknowledge is
// ended after ACK_TIMEOUT cycles with SLVERR. Also releases the bus reset.

`default_nettype none

module sys_bus_ctrl #(
  parameter int ADDR_W      = ps_bus_pkg::ADDR_W_DEF,
  parameter int ACK_TIMEOUT = ps_bus_pkg::ACK_TIMEOUT_DEF
) (
  input  logic                          axi0_clk_i,
  input  logic                          rst_n_i,
  // write request
  input  logic                          wr_req_i,
  input  logic [ADDR_W-1:0]             wr_addr_i,
  input  logic [ps_bus_pkg::DATA_W-1:0] wr_data_i,
  input  logic [ps_bus_pkg::STRB_W-1:0] wr_strb_i,
  output logic                          wr_done_o,
  output ps_bus_pkg::axi_resp_t         wr_resp_o,
  // read request
  input  logic                          rd_req_i,
  input  logic [ADDR_W-1:0]             rd_addr_i,
  output logic                          rd_done_o,
  output ps_bus_pkg::axi_resp_t         rd_resp_o,
  output logic [ps_bus_pkg::DATA_W-1:0] rd_data_o,
  // system bus
  output logic [ADDR_W-1:0]             sys_addr_o,
  output logic [ps_bus_pkg::DATA_W-1:0] sys_wdata_o,
  output logic [ps_bus_pkg::STRB_W-1:0] sys_sel_o,
  output logic                          sys_wen_o,
  output logic                          sys_ren_o,
  input  logic [ps_bus_pkg::DATA_W-1:0] sys_rdata_i,
  input  logic                          sys_err_i,
  input  logic                          sys_ack_i,
  output logic                          sys_rstn_o
);

  import ps_bus_pkg::*;

  localparam int CNT_W = $clog2(ACK_TIMEOUT);

  typedef enum logic [1:0] {ST_IDLE, ST_STROBE, ST_WAIT} state_t;

  state_t     state;
  logic       cur_wr;    // transaction in flight is a write
  logic       last_wr;   // last grant went to the writer
  logic [CNT_W-1:0] cnt; // cycles since strobe
  logic       wr_pend;
  logic       rd_pend;
  logic       grant_wr;
  logic       grant_rd;
  logic       timeout;
  logic       finish;
  logic       fail;
  logic [1:0] rst_pipe;

  // a request is still high in its done cycle
  assign wr_pend  = wr_req_i & ~wr_done_o;
  assign rd_pend  = rd_req_i & ~rd_done_o;
  assign grant_wr = (state == ST_IDLE) & wr_pend & (~rd_pend | ~last_wr);
  assign grant_rd = (state == ST_IDLE) & rd_pend & ~grant_wr;

  assign timeout = (cnt == CNT_W'(ACK_TIMEOUT - 1));
  assign finish  = (state != ST_IDLE) & (sys_ack_i | timeout);
  assign fail    = ~sys_ack_i | sys_err_i;

  assign sys_wen_o = (state == ST_STROBE) & cur_wr;
  assign sys_ren_o = (state == ST_STROBE) & ~cur_wr;

  // ------------------------------
  // transaction FSM
  // ------------------------------
  always_ff @(posedge axi0_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state     <= ST_IDLE;
      cur_wr    <= 1'b0;
      last_wr   <= 1'b0;
      cnt       <= '0;
      wr_done_o <= 1'b0;
      rd_done_o <= 1'b0;
      wr_resp_o <= RESP_OKAY;
      rd_resp_o <= RESP_OKAY;
    end else begin
      wr_done_o <= 1'b0;  // single-cycle pulses
      rd_done_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (grant_wr || grant_rd) begin
            state   <= ST_STROBE;
            cur_wr  <= grant_wr;
            last_wr <= grant_wr;
            cnt     <= '0;
          end
        end
        ST_STROBE, ST_WAIT: begin
          if (finish) begin
            state <= ST_IDLE;
            if (cur_wr) begin
              wr_done_o <= 1'b1;
              wr_resp_o <= fail ? RESP_SLVERR : RESP_OKAY;
            end else begin
              rd_done_o <= 1'b1;
              rd_resp_o <= fail ? RESP_SLVERR : RESP_OKAY;
            end
          end else begin
            state <= ST_WAIT;
            cnt   <= cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // bus payload, held from grant to done
  always_ff @(posedge axi0_clk_i) begin
    if (grant_wr) begin
      sys_addr_o  <= wr_addr_i;
      sys_wdata_o <= wr_data_i;
      sys_sel_o   <= wr_strb_i;
    end else if (grant_rd) begin
      sys_addr_o <= rd_addr_i;
    end
    if (finish && !cur_wr)
      rd_data_o <= fail ? '0 : sys_rdata_i;  // failed read returns zero
  end

  // ------------------------------
  // bus reset release
  // ------------------------------
  always_ff @(posedge axi0_clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      rst_pipe <= '0;
    else
      rst_pipe <= {rst_pipe[0], 1'b1};
  end

  assign sys_rstn_o = rst_pipe[1];

endmodule : sys_bus_ctrl

`default_nettype wire

//--- hdl/ps_bus_top.sv
// PS general-purpose AXI4-Lite slave
// Bridges the AXI4-Lite port onto the simple system bus through separate
// write and read channels and a shared bus controller.

`default_nettype none

module ps_bus_top #(
  parameter int ADDR_W      = ps_bus_pkg::ADDR_W_DEF,
  parameter int ACK_TIMEOUT = ps_bus_pkg::ACK_TIMEOUT_DEF
) (
  input  logic                          axi0_clk_i,
  input  logic                          rst_n_i,
  // AXI4-Lite slave port
  input  logic [ADDR_W-1:0]             awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [ps_bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [ps_bus_pkg::STRB_W-1:0] wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output ps_bus_pkg::axi_resp_t         bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  input  logic [ADDR_W-1:0]             araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output logic [ps_bus_pkg::DATA_W-1:0] rdata_o,
  output ps_bus_pkg::axi_resp_t         rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  // system bus
  output logic [ADDR_W-1:0]             sys_addr_o,
  output logic [ps_bus_pkg::DATA_W-1:0] sys_wdata_o,
  output logic [ps_bus_pkg::STRB_W-1:0] sys_sel_o,
  output logic                          sys_wen_o,
  output logic                          sys_ren_o,
  output logic                          sys_rstn_o,
  input  logic [ps_bus_pkg::DATA_W-1:0] sys_rdata_i,
  input  logic                          sys_err_i,
  input  logic                          sys_ack_i
);

  import ps_bus_pkg::*;

  logic              wr_req;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;
  logic              wr_done;
  axi_resp_t         wr_resp;
  logic              rd_req;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_done;
  axi_resp_t         rd_resp;
  logic [DATA_W-1:0] rd_data;

  axil_wr_channel #(
    .ADDR_W (ADDR_W)
  ) wr_ch0 (
    .axi0_clk_i (axi0_clk_i),
    .rst_n_i    (rst_n_i),
    .awaddr_i   (awaddr_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .bresp_o    (bresp_o),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .wr_req_o   (wr_req),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_strb_o  (wr_strb),
    .wr_done_i  (wr_done),
    .wr_resp_i  (wr_resp)
  );

  axil_rd_channel #(
    .ADDR_W (ADDR_W)
  ) rd_ch0 (
    .axi0_clk_i (axi0_clk_i),
    .rst_n_i    (rst_n_i),
    .araddr_i   (araddr_i),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .rd_req_o   (rd_req),
    .rd_addr_o  (rd_addr),
    .rd_done_i  (rd_done),
    .rd_resp_i  (rd_resp),
    .rd_data_i  (rd_data)
  );

  sys_bus_ctrl #(
    .ADDR_W      (ADDR_W),
    .ACK_TIMEOUT (ACK_TIMEOUT)
  ) bus_ctrl0 (
    .axi0_clk_i  (axi0_clk_i),
    .rst_n_i     (rst_n_i),
    .wr_req_i    (wr_req),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .wr_done_o   (wr_done),
    .wr_resp_o   (wr_resp),
    .rd_req_i    (rd_req),
    .rd_addr_i   (rd_addr),
    .rd_done_o   (rd_done),
    .rd_resp_o   (rd_resp),
    .rd_data_o   (rd_data),
    .sys_addr_o  (sys_addr_o),
    .sys_wdata_o (sys_wdata_o),
    .sys_sel_o   (sys_sel_o),
    .sys_wen_o   (sys_wen_o),
    .sys_ren_o   (sys_ren_o),
    .sys_rdata_i (sys_rdata_i),
    .sys_err_i   (sys_err_i),
    .sys_ack_i   (sys_ack_i),
    .sys_rstn_o  (sys_rstn_o)
  );

endmodule : ps_bus_top

`default_nettype wire

//--- sim/ps_bus_properties.sv
// System-bus protocol properties
// Bound to the system-bus controller. Checks strobe exclusivity, single-cycle
// strobes and a stable bus address from strobe until the done pulse.

`default_nettype none

module ps_bus_properties #(
  parameter int ADDR_W = 32
) (
  input logic              axi0_clk_i,
  input logic              rst_n_i,
  input logic              sys_wen_i,
  input logic              sys_ren_i,
  input logic [ADDR_W-1:0] sys_addr_i,
  input logic              wr_done_i,
  input logic              rd_done_i
);

  int   fail_excl  = 0;  // failures per property
  int   fail_pulse = 0;
  int   fail_addr  = 0;
  logic in_flight;       // strobe seen, done not yet

  always_ff @(posedge axi0_clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      in_flight <= 1'b0;
    else if (sys_wen_i || sys_ren_i)
      in_flight <= 1'b1;
    else if (wr_done_i || rd_done_i)
      in_flight <= 1'b0;
  end

  a_strobe_excl : assert property (@(posedge axi0_clk_i) disable iff (!rst_n_i)
    !(sys_wen_i && sys_ren_i))
    else begin
      fail_excl = fail_excl + 1;
      $error("sys_wen_o and sys_ren_o high together");
    end

  a_strobe_pulse : assert property (@(posedge axi0_clk_i) disable iff (!rst_n_i)
    (sys_wen_i || sys_ren_i) |=> !(sys_wen_i || sys_ren_i))
    else begin
      fail_pulse = fail_pulse + 1;
      $error("bus strobe longer than one cycle");
    end

  a_addr_stable : assert property (@(posedge axi0_clk_i) disable iff (!rst_n_i)
    in_flight |-> $stable(sys_addr_i))
    else begin
      fail_addr = fail_addr + 1;
      $error("sys_addr_o changed before done");
    end

endmodule : ps_bus_properties

bind sys_bus_ctrl ps_bus_properties #(.ADDR_W(ADDR_W)) props0 (
  .axi0_clk_i (axi0_clk_i),
  .rst_n_i    (rst_n_i),
  .sys_wen_i  (sys_wen_o),
  .sys_ren_i  (sys_ren_o),
  .sys_addr_i (sys_addr_o),
  .wr_done_i  (wr_done_o),
  .rd_done_i  (rd_done_o)
);

`default_nettype wire

//--- sim/tb_checker.sv
// Response checker
// Watches the B and R handshakes, the channel ready rules and the reset
// behavior of the DUT and compares them with the expected values queued
// by the testbench.

`default_nettype none

module tb_checker (
  input  logic        axi0_clk_i,
  input  logic        rst_n_i,
  input  logic        awvalid_i,
  input  logic        awready_i,
  input  logic        wvalid_i,
  input  logic        wready_i,
  input  logic        arvalid_i,
  input  logic        arready_i,
  input  logic        bvalid_i,
  input  logic        bready_i,
  input  logic [1:0]  bresp_i,
  input  logic        rvalid_i,
  input  logic        rready_i,
  input  logic [1:0]  rresp_i,
  input  logic [31:0] rdata_i,
  input  logic        sys_wen_i,
  input  logic        sys_ren_i,
  input  logic        sys_rstn_i,
  input  logic        push_wr_i,
  input  logic [1:0]  exp_wresp_i,
  input  logic        push_rd_i,
  input  logic [1:0]  exp_rresp_i,
  input  logic [31:0] exp_rdata_i,
  output int          err_cnt_o,
  output int          chk_cnt_o,
  output int          pend_cnt_o
);

  logic [1:0]  wr_q [$];  // expected bresp
  logic [33:0] rd_q [$];  // expected {rresp, rdata}
  int          since_rel;
  logic        b_held;
  logic [1:0]  b_saved;
  logic        r_held;
  logic [33:0] r_saved;
  logic        aw_busy;   // address taken, B not yet accepted
  logic        w_busy;
  logic        ar_busy;

  initial begin
    err_cnt_o  = 0;
    chk_cnt_o  = 0;
    pend_cnt_o = 0;
  end

  task automatic check(input logic ok, input string msg);
    chk_cnt_o++;
    if (!ok) begin
      err_cnt_o++;
      $display("ERROR %0t: %s", $time, msg);
    end
  endtask

  always @(posedge axi0_clk_i) begin
    logic [1:0]  exp_b;
    logic [33:0] exp_r;
    if (!rst_n_i) begin
      check(!(bvalid_i | rvalid_i | sys_wen_i | sys_ren_i), "valid or strobe high in reset");
      check(awready_i && wready_i && arready_i, "ready low in reset");
      check(!sys_rstn_i, "bus reset released during reset");
      since_rel <= 0;
      b_held    <= 1'b0;
      r_held    <= 1'b0;
      aw_busy   <= 1'b0;
      w_busy    <= 1'b0;
      ar_busy   <= 1'b0;
    end else begin
      // ------------------------------
      // reset release
      // ------------------------------
      if (since_rel < 2) begin
        check(!(bvalid_i | rvalid_i | sys_wen_i | sys_ren_i),
              "valid or strobe high right after reset");
        check(awready_i && wready_i && arready_i, "ready low right after reset");
        check(!sys_rstn_i, "bus reset released too early");
        since_rel <= since_rel + 1;
      end else begin
        check(sys_rstn_i, "bus reset not released");
      end
      // ------------------------------
      // channel ready rules
      // ------------------------------
      if (aw_busy)
        check(!awready_i, "awready high before write response taken");
      if (w_busy)
        check(!wready_i, "wready high before write response taken");
      if (ar_busy)
        check(!arready_i, "arready high before read response taken");
      if (awvalid_i && awready_i)
        aw_busy <= 1'b1;
      if (wvalid_i && wready_i)
        w_busy <= 1'b1;
      if (bvalid_i && bready_i) begin
        aw_busy <= 1'b0;
        w_busy  <= 1'b0;
      end
      if (arvalid_i && arready_i)
        ar_busy <= 1'b1;
      if (rvalid_i && rready_i)
        ar_busy <= 1'b0;
      // ------------------------------
      // hold stability under back-pressure
      // ------------------------------
      if (b_held)
        check(bvalid_i && bresp_i == b_saved, "write response changed before bready");
      if (r_held)
        check(rvalid_i && {rresp_i, rdata_i} == r_saved, "read response changed before rready");
      b_held  <= bvalid_i & ~bready_i;
      b_saved <= bresp_i;
      r_held  <= rvalid_i & ~rready_i;
      r_saved <= {rresp_i, rdata_i};
      // ------------------------------
      // handshakes
      // ------------------------------
      if (bvalid_i && bready_i) begin
        if (wr_q.size() == 0) begin
          check(1'b0, "write response with nothing expected");
        end else begin
          exp_b = wr_q.pop_front();
          check(bresp_i == exp_b, $sformatf("bresp %0d, expected %0d", bresp_i, exp_b));
        end
      end
      if (rvalid_i && rready_i) begin
        if (rd_q.size() == 0) begin
          check(1'b0, "read response with nothing expected");
        end else begin
          exp_r = rd_q.pop_front();
          check(rresp_i == exp_r[33:32],
                $sformatf("rresp %0d, expected %0d", rresp_i, exp_r[33:32]));
          check(rdata_i == exp_r[31:0],
                $sformatf("rdata %h, expected %h", rdata_i, exp_r[31:0]));
        end
      end
    end
    if (push_wr_i)
      wr_q.push_back(exp_wresp_i);
    if (push_rd_i)
      rd_q.push_back({exp_rresp_i, exp_rdata_i});
    pend_cnt_o = wr_q.size() + rd_q.size();
  end

endmodule : tb_checker

`default_nettype wire

//--- sim/tb_top.sv
// Testbench top for the PS AXI4-Lite to system-bus bridge
// Clock and reset, stimulus table, AXI4-Lite driver and a system-bus
// responder with a 16-word memory, an error region and a silent region.

`default_nettype none

module tb_top;

  localparam int         ACK_TO     = 8;
  localparam int         HS_LIMIT   = 16;               // cycles for an AW/W/AR handshake
  localparam int         RESP_LIMIT = 2 * (ACK_TO + 4); // incl. waiting for the other channel
  localparam logic [1:0] OKAY       = 2'b00;
  localparam logic [1:0] SLVERR     = 2'b10;
  localparam logic [1:0] OP_WR      = 2'd0;
  localparam logic [1:0] OP_RD      = 2'd1;
  localparam logic [1:0] OP_WRRD    = 2'd2;              // write to addr and read from addr + 4
  localparam int         NROWS      = 14;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [1:0]  resp;
    logic [31:0] rdata;
  } row_t;

  // ------------------------------
  // stimulus table
  // ------------------------------
  row_t stim [NROWS] = '{
    '{OP_WR,   32'h0000_0000, 32'h1122_3344, 4'hF, OKAY,   32'h0},
    '{OP_RD,   32'h0000_0000, 32'h0,         4'h0, OKAY,   32'h1122_3344},
    '{OP_WR,   32'h0000_000C, 32'hA5A5_A5A5, 4'hF, OKAY,   32'h0},
    '{OP_WR,   32'h0000_000C, 32'h5A5A_5A5A, 4'h5, OKAY,   32'h0},
    '{OP_RD,   32'h0000_000C, 32'h0,         4'h0, OKAY,   32'hA55A_A55A},
    '{OP_WR,   32'h0000_1004, 32'h1234_5678, 4'hF, SLVERR, 32'h0},
    '{OP_RD,   32'h0000_1008, 32'h0,         4'h0, SLVERR, 32'h0},
    '{OP_WR,   32'h0000_F000, 32'h8765_4321, 4'hF, SLVERR, 32'h0},
    '{OP_RD,   32'h0000_F010, 32'h0,         4'h0, SLVERR, 32'h0},
    '{OP_WR,   32'h0000_001C, 32'h0BAD_F00D, 4'hF, OKAY,   32'h0},
    '{OP_WRRD, 32'h0000_0018, 32'hDEAD_BEEF, 4'hF, OKAY,   32'h0BAD_F00D},
    '{OP_RD,   32'h0000_0018, 32'h0,         4'h0, OKAY,   32'hDEAD_BEEF},
    '{OP_WRRD, 32'h0000_1000, 32'hCAFE_0001, 4'h3, SLVERR, 32'h0},
    '{OP_WRRD, 32'h0000_F020, 32'hCAFE_0002, 4'hF, SLVERR, 32'h0}
  };

  logic        axi0_clk = 1'b0;
  logic        rst_n;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [31:0] sys_addr;
  logic [31:0] sys_wdata;
  logic [3:0]  sys_sel;
  logic        sys_wen;
  logic        sys_ren;
  logic        sys_rstn;
  logic [31:0] sys_rdata;
  logic        sys_err;
  logic        sys_ack;
  logic        push_wr;
  logic [1:0]  exp_wresp;
  logic        push_rd;
  logic [1:0]  exp_rresp;
  logic [31:0] exp_rdata;
  int          err_cnt;
  int          chk_cnt;
  int          pend_cnt;
  int          timeouts = 0;
  int          seed     = 32'h9172_44f2;

  always #2 axi0_clk = ~axi0_clk;

  initial begin
    rst_n   <= 1'b0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    sys_ack   <= 1'b0;
    sys_err   <= 1'b0;
    sys_rdata <= '0;
    push_wr <= 1'b0;
    push_rd <= 1'b0;
    exp_wresp <= OKAY;
    exp_rresp <= OKAY;
    exp_rdata <= '0;
  end

  ps_bus_top #(
    .ADDR_W      (32),
    .ACK_TIMEOUT (ACK_TO)
  ) dut0 (
    .axi0_clk_i (axi0_clk), .rst_n_i (rst_n),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .sys_addr_o (sys_addr), .sys_wdata_o (sys_wdata), .sys_sel_o (sys_sel),
    .sys_wen_o (sys_wen), .sys_ren_o (sys_ren), .sys_rstn_o (sys_rstn),
    .sys_rdata_i (sys_rdata), .sys_err_i (sys_err), .sys_ack_i (sys_ack)
  );

  tb_checker chk0 (
    .axi0_clk_i (axi0_clk), .rst_n_i (rst_n),
    .awvalid_i (awvalid), .awready_i (awready),
    .wvalid_i (wvalid), .wready_i (wready),
    .arvalid_i (arvalid), .arready_i (arready),
    .bvalid_i (bvalid), .bready_i (bready), .bresp_i (bresp),
    .rvalid_i (rvalid), .rready_i (rready), .rresp_i (rresp), .rdata_i (rdata),
    .sys_wen_i (sys_wen), .sys_ren_i (sys_ren), .sys_rstn_i (sys_rstn),
    .push_wr_i (push_wr), .exp_wresp_i (exp_wresp),
    .push_rd_i (push_rd), .exp_rresp_i (exp_rresp), .exp_rdata_i (exp_rdata),
    .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt), .pend_cnt_o (pend_cnt)
  );

  // ------------------------------
  // system-bus responder
  // ------------------------------
  logic [31:0] mem [16];
  logic [3:0]  region;
  logic [3:0]  idx;
  logic        rsp_busy;
  logic [1:0]  rsp_wait;

  assign region = sys_addr[15:12];
  assign idx    = sys_addr[5:2];

  initial begin
    for (int k = 0; k < 16; k++)
      mem[k] <= 32'h5EED_0000 | 32'(k * 4);  // address-based fill
  end

  task automatic drive_ack();
    sys_ack   <= 1'b1;
    sys_err   <= (region == 4'h1);
    sys_rdata <= (region == 4'h0) ? mem[idx] : 32'hBAD0_BAD0;  // junk outside memory
  endtask

  always @(posedge axi0_clk) begin
    sys_ack   <= 1'b0;
    sys_err   <= 1'b0;
    sys_rdata <= '0;
    if (rst_n !== 1'b1) begin
      rsp_busy <= 1'b0;
    end else if (sys_wen || sys_ren) begin
      if (sys_wen && region == 4'h0) begin
        for (int b = 0; b < 4; b++)
          if (sys_sel[b])
            mem[idx][8*b +: 8] <= sys_wdata[8*b +: 8];  // byte strobes
      end
      rsp_busy <= 1'b0;
      if (region != 4'hF) begin  // region F stays silent
        if (sys_addr[3:2] == 2'd0) begin
          drive_ack();
        end else begin
          rsp_busy <= 1'b1;
          rsp_wait <= sys_addr[3:2] - 2'd1;
        end
      end
    end else if (rsp_busy) begin
      if (rsp_wait == 2'd0) begin
        rsp_busy <= 1'b0;
        drive_ack();
      end else begin
        rsp_wait <= rsp_wait - 2'd1;
      end
    end
  end

  // ------------------------------
  // AXI4-Lite driver
  // ------------------------------
  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout: %s did not complete within its cycle limit", what);
  endtask

  task automatic send_aw(input logic [31:0] a);
    int t;
    t = 0;
    awaddr  <= a;
    awvalid <= 1'b1;
    do begin
      @(posedge axi0_clk);
      t++;
    end while (!awready && t < HS_LIMIT);
    awvalid <= 1'b0;
    if (!awready)
      note_timeout("AW handshake");
  endtask

  task automatic send_w(input logic [31:0] d, input logic [3:0] s);
    int t;
    t = 0;
    wdata  <= d;
    wstrb  <= s;
    wvalid <= 1'b1;
    do begin
      @(posedge axi0_clk);
      t++;
    end while (!wready && t < HS_LIMIT);
    wvalid <= 1'b0;
    if (!wready)
      note_timeout("W handshake");
  endtask

  task automatic send_ar(input logic [31:0] a);
    int t;
    t = 0;
    araddr  <= a;
    arvalid <= 1'b1;
    do begin
      @(posedge axi0_clk);
      t++;
    end while (!arready && t < HS_LIMIT);
    arvalid <= 1'b0;
    if (!arready)
      note_timeout("AR handshake");
  endtask

  task automatic take_b();
    int t;
    int hold;
    t    = 0;
    hold = $random(seed) & 3;  // bready hold-off
    do begin
      @(posedge axi0_clk);
      t++;
    end while (!bvalid && t < RESP_LIMIT);
    if (!bvalid) begin
      note_timeout("write response");
    end else begin
      repeat (hold) @(posedge axi0_clk);
      bready <= 1'b1;
      @(posedge axi0_clk);
      bready <= 1'b0;
    end
  endtask

  task automatic take_r();
    int t;
    int hold;
    t    = 0;
    hold = $random(seed) & 3;
    do begin
      @(posedge axi0_clk);
      t++;
    end while (!rvalid && t < RESP_LIMIT);
    if (!rvalid) begin
      note_timeout("read response");
    end else begin
      repeat (hold) @(posedge axi0_clk);
      rready <= 1'b1;
      @(posedge axi0_clk);
      rready <= 1'b0;
    end
  endtask

  task automatic do_write(input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] s, input logic [1:0] r);
    int order;
    order = $random(seed) & 3;
    @(posedge axi0_clk);
    push_wr   <= 1'b1;
    exp_wresp <= r;
    @(posedge axi0_clk);
    push_wr <= 1'b0;
    case (order)
      1: begin
        send_aw(a);  // AW before W
        send_w(d, s);
      end
      2: begin
        send_w(d, s);  // W before AW
        send_aw(a);
      end
      default: fork
        send_aw(a);
        send_w(d, s);
      join
    endcase
    take_b();
  endtask

  task automatic do_read(input logic [31:0] a, input logic [1:0] r, input logic [31:0] d);
    @(posedge axi0_clk);
    push_rd   <= 1'b1;
    exp_rresp <= r;
    exp_rdata <= d;
    @(posedge axi0_clk);
    push_rd <= 1'b0;
    send_ar(a);
    take_r();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int i;
    int assert_fails;
    repeat (16) @(posedge axi0_clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge axi0_clk);
    for (i = 0; i < NROWS; i++) begin
      case (stim[i].op)
        OP_WR: do_write(stim[i].addr, stim[i].wdata, stim[i].strb, stim[i].resp);
        OP_RD: do_read(stim[i].addr, stim[i].resp, stim[i].rdata);
        default: fork
          do_write(stim[i].addr, stim[i].wdata, stim[i].strb, stim[i].resp);
          do_read(stim[i].addr + 32'd4, stim[i].resp, stim[i].rdata);
        join
      endcase
      if (timeouts != 0)
        break;
    end
    repeat (4) @(posedge axi0_clk);
    assert_fails = dut0.bus_ctrl0.props0.fail_excl + dut0.bus_ctrl0.props0.fail_pulse
                 + dut0.bus_ctrl0.props0.fail_addr;
    if (pend_cnt != 0)
      $display("%0d expected responses were never seen", pend_cnt);
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             chk_cnt, err_cnt, assert_fails, timeouts);
    if (err_cnt == 0 && assert_fails == 0 && timeouts == 0 && pend_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule : tb_top

`default_nettype wire

//--- files.f
hdl/ps_bus_pkg.sv
hdl/axil_wr_channel.sv
hdl/axil_rd_channel.sv
hdl/sys_bus_ctrl.sv
hdl/ps_bus_top.sv
sim/ps_bus_properties.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -o tb_sim -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
